/* design/rv_isa_pkg.sv */
package rv_isa_pkg;

    // ######################################################################
    // Widths and vector types
    // ######################################################################

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;   // Data word
    typedef logic [XLEN-1:0] pc_t;     // Byte address
    typedef logic [4:0]      reg_idx_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [6:0]      funct7_t;

    // ######################################################################
    // Opcodes
    // ######################################################################

    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;

    // ######################################################################
    // Function fields
    // ######################################################################

    localparam funct3_t F3_ADD_SUB = 3'b000;   // ADD, SUB, ADDI
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;
    localparam funct3_t F3_LW      = 3'b010;
    localparam funct3_t F3_SW      = 3'b010;
    localparam funct3_t F3_BEQ     = 3'b000;
    localparam funct3_t F3_BNE     = 3'b001;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_SUB  = 7'b0100000;

    // Store here goes to the LED register, not to data memory
    localparam word_t LED_ADDR = 32'h0000_0400;

endpackage

/* design/pipe_pkg.sv */
package pipe_pkg;

    import rv_isa_pkg::*;

    // ######################################################################
    // Control encodings
    // ######################################################################

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B   // LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_LINK      // pc + 4 for JAL
    } wb_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    branch;
        logic    branch_ne;
        logic    jump;
        wb_sel_e wb_sel;
    } ctrl_t;

    // ######################################################################
    // Stage registers
    // ######################################################################

    typedef struct packed {
        logic  valid;
        pc_t   pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        pc_t      pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;        // Zero when the instruction writes nothing
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;
        ctrl_t    ctrl;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        pc_t      pc;
        reg_idx_t rd;
        word_t    alu_result;
        word_t    store_data;
        word_t    link;
        ctrl_t    ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        pc_t      pc;
        reg_idx_t rd;
        word_t    alu_result;
        word_t    load_data;
        word_t    link;
        logic     reg_write;
        wb_sel_e  wb_sel;
    } mem_wb_t;

    typedef struct packed {
        pc_t      pc;
        reg_idx_t rd;
        word_t    value;
    } retire_t;

    // Writeback value of the MEM/WB register
    function automatic word_t wb_value(input mem_wb_t r);
        case (r.wb_sel)
            WB_LOAD: return r.load_data;
            WB_LINK: return r.link;
            default: return r.alu_result;
        endcase
    endfunction

endpackage

/* design/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit
    import rv_isa_pkg::*, pipe_pkg::*;
#(
    parameter int IMEM_WORDS = 256
) (
    input  logic   cpuclk,
    input  logic   arst_n,
    input  logic   core_run,
    input  logic   load_en,
    input  pc_t    load_addr,
    input  word_t  load_data,
    input  logic   stall,
    input  logic   redirect,
    input  pc_t    redirect_pc,
    output if_id_t if_id
);

    localparam int IW = $clog2(IMEM_WORDS);

    word_t imem [IMEM_WORDS];
    pc_t   pc;
    word_t instr;

    // Loader writes whole words
    always_ff @(posedge cpuclk) begin
        if (load_en)
            imem[load_addr[IW+1:2]] <= load_data;
    end

    assign instr = imem[pc[IW+1:2]];

    always_ff @(posedge cpuclk or negedge arst_n) begin
        if (!arst_n) begin
            pc    <= '0;
            if_id <= '0;
        end else if (!core_run) begin
            pc    <= '0;
            if_id <= '0;
        end else if (redirect) begin
            pc    <= redirect_pc;
            if_id <= '0;            // Drop the wrong-path fetch
        end else if (!stall) begin
            pc    <= pc + 32'd4;
            if_id <= '{valid: 1'b1, pc: pc, instr: instr};
        end
    end

    // Program image is complete before the core starts
    a_no_load_while_running : assert property (
        @(posedge cpuclk) disable iff (!arst_n) !(load_en && core_run));

endmodule

/* design/decode_unit.sv */
`timescale 1ns/1ns

module decode_unit
    import rv_isa_pkg::*, pipe_pkg::*;
(
    input  logic    cpuclk,
    input  logic    arst_n,
    input  if_id_t  if_id,
    input  mem_wb_t mem_wb,
    input  id_ex_t  id_ex_q_in,
    input  logic    redirect,
    output logic    stall,
    output id_ex_t  id_ex
);

    word_t    instr;
    opcode_t  opcode;
    funct3_t  f3;
    funct7_t  f7;
    ctrl_t    ctrl;
    word_t    imm;
    logic     use_rs1, use_rs2;
    reg_idx_t rs1, rs2, rd;

    word_t    regs [32];
    logic     rf_we;
    word_t    rf_wdata;
    word_t    rs1_val, rs2_val;
    id_ex_t   id_ex_d;

    assign instr  = if_id.instr;
    assign opcode = instr[6:0];
    assign f3     = instr[14:12];
    assign f7     = instr[31:25];

    function automatic alu_op_e alu_for(input funct3_t fn, input logic sub);
        case (fn)
            F3_ADD_SUB: return sub ? ALU_SUB : ALU_ADD;
            F3_SLT:     return ALU_SLT;
            F3_XOR:     return ALU_XOR;
            F3_OR:      return ALU_OR;
            F3_AND:     return ALU_AND;
            default:    return ALU_ADD;
        endcase
    endfunction

    // ######################################################################
    // Instruction decode
    // ######################################################################

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        ctrl.wb_sel = WB_ALU;
        imm         = '0;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        case (opcode)
            OP_REG: begin
                if (f7 == F7_BASE || (f7 == F7_SUB && f3 == F3_ADD_SUB)) begin
                    ctrl.alu_op    = alu_for(f3, f7 == F7_SUB);
                    ctrl.reg_write = 1'b1;
                    use_rs1        = 1'b1;
                    use_rs2        = 1'b1;
                end
            end
            OP_IMM: begin
                ctrl.alu_op      = alu_for(f3, 1'b0);
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                imm              = {{20{instr[31]}}, instr[31:20]};
                use_rs1          = 1'b1;
            end
            OP_LUI: begin
                ctrl.alu_op      = ALU_PASS_B;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                imm              = {instr[31:12], 12'b0};
            end
            OP_LOAD: begin
                if (f3 == F3_LW) begin
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.mem_read    = 1'b1;
                    ctrl.reg_write   = 1'b1;
                    ctrl.wb_sel      = WB_LOAD;
                    imm              = {{20{instr[31]}}, instr[31:20]};
                    use_rs1          = 1'b1;
                end
            end
            OP_STORE: begin
                if (f3 == F3_SW) begin
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.mem_write   = 1'b1;
                    imm              = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                    use_rs1          = 1'b1;
                    use_rs2          = 1'b1;
                end
            end
            OP_BRANCH: begin
                if (f3 == F3_BEQ || f3 == F3_BNE) begin
                    ctrl.branch    = 1'b1;
                    ctrl.branch_ne = (f3 == F3_BNE);
                    imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                end
            end
            OP_JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_LINK;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: ;                   // Unknown opcode runs as a nop
        endcase
    end

    // Unused fields read as x0 so they never match a hazard
    assign rs1 = use_rs1 ? instr[19:15] : '0;
    assign rs2 = use_rs2 ? instr[24:20] : '0;
    assign rd  = ctrl.reg_write ? instr[11:7] : '0;

    // ######################################################################
    // Register file with write-first bypass
    // ######################################################################

    assign rf_we    = mem_wb.valid && mem_wb.reg_write && (mem_wb.rd != '0);
    assign rf_wdata = wb_value(mem_wb);

    always_ff @(posedge cpuclk) begin
        if (rf_we)
            regs[mem_wb.rd] <= rf_wdata;
    end

    always_comb begin
        rs1_val = (rs1 == '0) ? '0 : (rf_we && mem_wb.rd == rs1) ? rf_wdata : regs[rs1];
        rs2_val = (rs2 == '0) ? '0 : (rf_we && mem_wb.rd == rs2) ? rf_wdata : regs[rs2];
    end

    // Load in execute feeding this instruction
    assign stall = if_id.valid && id_ex_q_in.valid && id_ex_q_in.ctrl.mem_read &&
                   (id_ex_q_in.rd != '0) && (id_ex_q_in.rd == rs1 || id_ex_q_in.rd == rs2);

    always_comb begin
        id_ex_d         = '0;
        id_ex_d.valid   = if_id.valid;
        id_ex_d.pc      = if_id.pc;
        id_ex_d.rs1     = rs1;
        id_ex_d.rs2     = rs2;
        id_ex_d.rd      = rd;
        id_ex_d.rs1_val = rs1_val;
        id_ex_d.rs2_val = rs2_val;
        id_ex_d.imm     = imm;
        id_ex_d.ctrl    = ctrl;
    end

    always_ff @(posedge cpuclk or negedge arst_n) begin
        if (!arst_n)
            id_ex <= '0;
        else if (redirect || stall || !if_id.valid)
            id_ex <= '0;                 // Bubble
        else
            id_ex <= id_ex_d;
    end

    // Load-use hazard holds decode for a single cycle
    a_stall_one_cycle : assert property (
        @(posedge cpuclk) disable iff (!arst_n)
        stall |=> !stall);

endmodule

/* design/execute_unit.sv */
`timescale 1ns/1ns

module execute_unit
    import rv_isa_pkg::*, pipe_pkg::*;
(
    input  logic    cpuclk,
    input  logic    arst_n,
    input  id_ex_t  id_ex,
    input  mem_wb_t mem_wb,
    output ex_mem_t ex_mem,
    output logic    redirect,
    output pc_t     redirect_pc
);

    word_t ex_fwd_val, wb_fwd_val;
    word_t op_a, rs2_fwd, op_b;
    word_t alu_y;
    logic  taken;

    // JAL in memory stage forwards its link value
    assign ex_fwd_val = (ex_mem.ctrl.wb_sel == WB_LINK) ? ex_mem.link : ex_mem.alu_result;
    assign wb_fwd_val = wb_value(mem_wb);

    // Nearest producer wins, x0 is never forwarded
    function automatic word_t fwd(input reg_idx_t src, input word_t rf_val);
        if (src == '0)
            return rf_val;
        if (ex_mem.valid && ex_mem.ctrl.reg_write && ex_mem.rd == src)
            return ex_fwd_val;
        if (mem_wb.valid && mem_wb.reg_write && mem_wb.rd == src)
            return wb_fwd_val;
        return rf_val;
    endfunction

    // ######################################################################
    // Operands and ALU
    // ######################################################################

    always_comb begin
        op_a    = fwd(id_ex.rs1, id_ex.rs1_val);
        rs2_fwd = fwd(id_ex.rs2, id_ex.rs2_val);
        op_b    = id_ex.ctrl.alu_src_imm ? id_ex.imm : rs2_fwd;
        case (id_ex.ctrl.alu_op)
            ALU_SUB:    alu_y = op_a - op_b;
            ALU_AND:    alu_y = op_a & op_b;
            ALU_OR:     alu_y = op_a | op_b;
            ALU_XOR:    alu_y = op_a ^ op_b;
            ALU_SLT:    alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_y = op_b;
            default:    alu_y = op_a + op_b;
        endcase
    end

    // Branches compare the two register operands
    assign taken = id_ex.valid &&
                   (id_ex.ctrl.jump ||
                    (id_ex.ctrl.branch && ((op_a == rs2_fwd) != id_ex.ctrl.branch_ne)));

    assign redirect    = taken;
    assign redirect_pc = id_ex.pc + id_ex.imm;

    always_ff @(posedge cpuclk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.pc         <= id_ex.pc;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.alu_result <= alu_y;
            ex_mem.store_data <= rs2_fwd;
            ex_mem.link       <= id_ex.pc + 32'd4;
            ex_mem.ctrl       <= id_ex.ctrl;
        end
    end

    // Decode squashes the slot behind a taken branch or jump
    a_redirect_flush : assert property (
        @(posedge cpuclk) disable iff (!arst_n)
        redirect |=> !id_ex.valid);

endmodule

/* design/data_mem.sv */
`timescale 1ns/1ns

module data_mem
    import rv_isa_pkg::*, pipe_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic       cpuclk,
    input  logic       arst_n,
    input  ex_mem_t    ex_mem,
    output mem_wb_t    mem_wb,
    output logic       retire_valid,
    output retire_t    retire,
    output logic [7:0] led
);

    localparam int AW = $clog2(DMEM_WORDS);

    word_t dmem [DMEM_WORDS];
    word_t load_data;
    logic  is_led;
    logic  store;

    assign is_led    = (ex_mem.alu_result == LED_ADDR);
    assign store     = ex_mem.valid && ex_mem.ctrl.mem_write;
    assign load_data = dmem[ex_mem.alu_result[AW+1:2]];   // Word aligned only

    always_ff @(posedge cpuclk) begin
        if (store && !is_led)
            dmem[ex_mem.alu_result[AW+1:2]] <= ex_mem.store_data;
    end

    always_ff @(posedge cpuclk or negedge arst_n) begin
        if (!arst_n) begin
            led    <= '0;
            mem_wb <= '0;
        end else begin
            if (store && is_led)
                led <= ex_mem.store_data[7:0];
            mem_wb <= '{valid: ex_mem.valid, pc: ex_mem.pc, rd: ex_mem.rd,
                        alu_result: ex_mem.alu_result, load_data: load_data,
                        link: ex_mem.link, reg_write: ex_mem.ctrl.reg_write,
                        wb_sel: ex_mem.ctrl.wb_sel};
        end
    end

    // Retire record
    assign retire_valid = mem_wb.valid;
    assign retire.pc    = mem_wb.pc;
    assign retire.rd    = mem_wb.rd;
    assign retire.value = (mem_wb.reg_write && mem_wb.rd != '0) ? wb_value(mem_wb) : '0;

endmodule

/* design/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top
    import rv_isa_pkg::*, pipe_pkg::*;
#(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic    cpuclk,
    input  logic    arst_n,
    // program loader
    input  logic    load_en,
    input  pc_t     load_addr,
    input  word_t   load_data,
    input  logic    load_done,
    // retire and LED
    output logic    retire_valid,
    output retire_t retire,
    output logic [7:0] led
);

    logic core_rst_n;   // Core stays in reset until the image is loaded

    assign core_rst_n = arst_n & load_done;

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    logic stall;
    logic redirect;
    pc_t  redirect_pc;

    fetch_unit #(
        .IMEM_WORDS(IMEM_WORDS)
    ) fetch_inst (
        .cpuclk,
        .arst_n,
        .core_run(load_done),
        .load_en,
        .load_addr,
        .load_data,
        .stall,
        .redirect,
        .redirect_pc,
        .if_id
    );

    decode_unit decode_inst (
        .cpuclk,
        .arst_n(core_rst_n),
        .if_id,
        .mem_wb,
        .id_ex_q_in(id_ex),
        .redirect,
        .stall,
        .id_ex
    );

    execute_unit execute_inst (
        .cpuclk,
        .arst_n(core_rst_n),
        .id_ex,
        .mem_wb,
        .ex_mem,
        .redirect,
        .redirect_pc
    );

    data_mem #(
        .DMEM_WORDS(DMEM_WORDS)
    ) data_mem_inst (
        .cpuclk,
        .arst_n(core_rst_n),
        .ex_mem,
        .mem_wb,
        .retire_valid,
        .retire,
        .led
    );

endmodule

/* tb/tb_checker.sv */
`timescale 1ns/1ns

module tb_checker
    import rv_isa_pkg::*, pipe_pkg::*;
#(
    parameter int WORDS = 256
) (
    input  logic       cpuclk,
    input  logic       arst_n,
    input  logic       start,
    input  word_t      image [WORDS],
    input  int         block_of [WORDS],
    input  logic       retire_valid,
    input  retire_t    retire,
    input  logic [7:0] led,
    output logic       ready,
    output logic       done,
    output int         n_expected,
    output int         pending,
    output int         errors
);

    localparam int IW = $clog2(WORDS);

    retire_t    exp_q [$];
    logic [7:0] exp_led;
    pc_t        halt_pc;
    int         value_errors = 0;
    int         led_errors   = 0;

    assign pending = exp_q.size();
    assign errors  = value_errors + led_errors;

    function automatic string block_name(input int b);
        case (b)
            0:       return "reg_init";
            1:       return "alu_ops";
            2:       return "forwarding";
            3:       return "load_store";
            4:       return "branches";
            5:       return "x0_writes";
            6:       return "led_store";
            7:       return "random_alu";
            default: return "halt";
        endcase
    endfunction

    function automatic word_t isa_op(input funct3_t f3, input logic sub,
                                     input word_t a, input word_t b);
        case (f3)
            F3_ADD_SUB: return sub ? a - b : a + b;
            F3_SLT:     return {31'b0, $signed(a) < $signed(b)};   // Signed compare
            F3_XOR:     return a ^ b;
            F3_OR:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    // ######################################################################
    // Instruction-set model, one retire record per executed instruction
    // ######################################################################

    function automatic void run_model();
        word_t   x [32];
        word_t   dmem [word_t];
        pc_t     pc;
        pc_t     next_pc;
        word_t   ins, a, b, addr, res;
        word_t   imm_i, imm_s, imm_b, imm_j;
        logic    wr;
        retire_t rec;
        x       = '{default: '0};
        pc      = '0;
        exp_led = '0;
        for (int step = 0; step < 4096; step++) begin
            ins     = image[pc[IW+1:2]];
            a       = x[ins[19:15]];
            b       = x[ins[24:20]];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            next_pc = pc + 32'd4;
            wr      = 1'b1;
            res     = '0;
            case (ins[6:0])
                OP_REG: res = isa_op(ins[14:12], ins[30], a, b);
                OP_IMM: res = isa_op(ins[14:12], 1'b0, a, imm_i);
                OP_LUI: res = {ins[31:12], 12'b0};
                OP_LOAD: begin
                    addr = a + imm_i;
                    res  = dmem.exists(addr) ? dmem[addr] : '0;
                end
                OP_STORE: begin
                    wr   = 1'b0;
                    addr = a + imm_s;
                    if (addr == LED_ADDR)
                        exp_led = b[7:0];
                    else
                        dmem[addr] = b;
                end
                OP_BRANCH: begin
                    wr = 1'b0;
                    if ((a == b) != ins[12])   // funct3 bit 0 selects BNE
                        next_pc = pc + imm_b;
                end
                OP_JAL: begin
                    res     = pc + 32'd4;
                    next_pc = pc + imm_j;
                end
                default: wr = 1'b0;
            endcase
            rec.pc    = pc;
            rec.rd    = wr ? ins[11:7] : 5'd0;
            rec.value = (wr && ins[11:7] != 5'd0) ? res : '0;
            exp_q.push_back(rec);
            if (wr && ins[11:7] != 5'd0)
                x[ins[11:7]] = res;
            if (next_pc == pc) begin   // Self-jump ends the program
                halt_pc = pc;
                break;
            end
            pc = next_pc;
        end
    endfunction

    initial begin
        ready      = 1'b0;
        done       = 1'b0;
        n_expected = 0;
        wait (start);
        @(negedge cpuclk);               // Image settled before the model reads it
        run_model();
        n_expected = exp_q.size();
        ready      = 1'b1;
        while (exp_q.size() != 0)
            @(negedge cpuclk);
        repeat (20) @(negedge cpuclk);   // Room for stray retires
        if (led !== exp_led) begin
            led_errors++;
            $display("Fail led_store: expected %h, actual %h", exp_led, led);
        end
        @(posedge cpuclk);
        done = 1'b1;
    end

    always @(negedge cpuclk) begin : compare
        retire_t want;
        if (arst_n && retire_valid) begin
            if (exp_q.size() == 0) begin
                if (retire.pc != halt_pc) begin
                    value_errors++;
                    $display("Extra retire at pc %h after the program ended", retire.pc);
                end
            end else begin
                want = exp_q.pop_front();
                if (retire !== want) begin
                    value_errors++;
                    $display("Fail %s: expected pc=%h rd=%0d value=%h, actual pc=%h rd=%0d value=%h",
                             block_name(block_of[want.pc[IW+1:2]]), want.pc, want.rd,
                             want.value, retire.pc, retire.rd, retire.value);
                end
            end
        end
    end

endmodule

/* tb/tb_top.sv */
`timescale 1ns/1ns

module tb_top
    import rv_isa_pkg::*, pipe_pkg::*;
();

    localparam int PROG_WORDS = 256;

    logic       cpuclk;
    logic       arst_n;
    logic       load_en;
    pc_t        load_addr;
    word_t      load_data;
    logic       load_done;
    logic       retire_valid;
    retire_t    retire;
    logic [7:0] led;

    word_t image [PROG_WORDS];
    int    block_of [PROG_WORDS];
    int    prog_len;
    int    cur_block;    // Block ids follow the names in tb_checker
    logic  start;
    logic  ready, done;
    int    n_expected, pending, errors;

    always #2 cpuclk = ~cpuclk;

    cpu_top #(
        .IMEM_WORDS(PROG_WORDS),
        .DMEM_WORDS(256)
    ) dut (
        .cpuclk, .arst_n, .load_en, .load_addr, .load_data, .load_done,
        .retire_valid, .retire, .led
    );

    tb_checker #(
        .WORDS(PROG_WORDS)
    ) monitor (
        .cpuclk, .arst_n, .start, .image, .block_of, .retire_valid, .retire, .led,
        .ready, .done, .n_expected, .pending, .errors
    );

    // ######################################################################
    // Instruction encoders
    // ######################################################################

    function automatic word_t r_type(input funct7_t f7, input funct3_t f3,
                                     input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_REG};
    endfunction

    function automatic word_t i_type(input opcode_t op, input funct3_t f3,
                                     input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic word_t s_type(input int rs1, input int rs2, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], F3_SW, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t b_type(input funct3_t f3, input int rs1, input int rs2,
                                     input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic word_t u_type(input int rd, input int imm);
        return {imm[19:0], rd[4:0], OP_LUI};
    endfunction

    function automatic word_t j_type(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
    endfunction

    task automatic emit(input word_t w);
        image[prog_len]    = w;
        block_of[prog_len] = cur_block;
        prog_len++;
    endtask

    task automatic build_program();
        funct3_t alu_f3 [6] = '{F3_ADD_SUB, F3_ADD_SUB, F3_AND, F3_OR, F3_XOR, F3_SLT};
        int      k, kind, imm;
        for (int i = 0; i < PROG_WORDS; i++) begin
            image[i]    = 32'h0000_0013;   // ADDI x0, x0, 0
            block_of[i] = 8;
        end
        prog_len  = 0;
        cur_block = 0;
        for (int r = 1; r < 32; r++)
            emit(i_type(OP_IMM, F3_ADD_SUB, r, 0, $urandom_range(4095, 0)));
        cur_block = 1;
        emit(u_type(5, 'h80000));   // Most negative word
        emit(i_type(OP_IMM, F3_ADD_SUB, 6, 0, 5));
        emit(r_type(F7_BASE, F3_SLT, 7, 5, 6));
        emit(r_type(F7_BASE, F3_SLT, 8, 6, 5));
        emit(i_type(OP_IMM, F3_SLT, 9, 5, -1));
        emit(r_type(F7_SUB, F3_ADD_SUB, 10, 6, 5));
        emit(r_type(F7_BASE, F3_AND, 11, 10, 5));
        emit(i_type(OP_IMM, F3_AND, 12, 10, 'hF0));
        emit(i_type(OP_IMM, F3_OR, 13, 6, -256));
        emit(i_type(OP_IMM, F3_XOR, 14, 5, -1));
        emit(r_type(F7_BASE, F3_XOR, 15, 14, 6));
        emit(r_type(F7_BASE, F3_OR, 16, 15, 7));
        emit(u_type(18, 'h12345));
        cur_block = 2;
        emit(r_type(F7_BASE, F3_ADD_SUB, 10, 6, 7));
        emit(r_type(F7_BASE, F3_ADD_SUB, 11, 10, 10));   // From EX/MEM
        emit(r_type(F7_BASE, F3_XOR, 12, 10, 11));       // MEM/WB and EX/MEM
        emit(r_type(F7_SUB, F3_ADD_SUB, 13, 12, 10));
        cur_block = 3;
        emit(i_type(OP_IMM, F3_ADD_SUB, 14, 0, 64));
        emit(s_type(14, 13, 0));
        emit(i_type(OP_LOAD, F3_LW, 15, 14, 0));
        emit(r_type(F7_BASE, F3_ADD_SUB, 16, 15, 15));   // Load-use
        emit(s_type(14, 16, 4));
        emit(i_type(OP_LOAD, F3_LW, 17, 14, 4));
        emit(r_type(F7_SUB, F3_ADD_SUB, 18, 17, 15));
        emit(s_type(14, 18, -4));
        emit(i_type(OP_LOAD, F3_LW, 20, 14, -4));
        emit(r_type(F7_BASE, F3_OR, 21, 0, 20));
        cur_block = 4;
        emit(i_type(OP_IMM, F3_ADD_SUB, 19, 0, 7));
        emit(i_type(OP_IMM, F3_ADD_SUB, 20, 0, 7));
        emit(b_type(F3_BEQ, 19, 20, 12));   // Taken, next two flushed
        emit(i_type(OP_IMM, F3_ADD_SUB, 21, 0, 1));
        emit(i_type(OP_IMM, F3_ADD_SUB, 21, 0, 2));
        emit(b_type(F3_BNE, 19, 20, 8));    // Not taken
        emit(i_type(OP_IMM, F3_ADD_SUB, 22, 0, 9));
        emit(b_type(F3_BNE, 19, 0, 8));
        emit(i_type(OP_IMM, F3_ADD_SUB, 22, 0, 1));
        emit(b_type(F3_BEQ, 19, 0, 8));     // Not taken
        emit(i_type(OP_IMM, F3_ADD_SUB, 23, 0, 4));
        emit(j_type(1, 8));
        emit(i_type(OP_IMM, F3_ADD_SUB, 24, 0, 1));
        emit(r_type(F7_BASE, F3_ADD_SUB, 25, 1, 0));    // Reads the link value
        cur_block = 5;
        emit(i_type(OP_IMM, F3_ADD_SUB, 0, 0, 123));
        emit(r_type(F7_BASE, F3_ADD_SUB, 26, 0, 0));
        emit(u_type(0, 'hABCDE));
        emit(r_type(F7_BASE, F3_OR, 27, 0, 19));
        emit(r_type(F7_BASE, F3_ADD_SUB, 0, 19, 20));
        emit(r_type(F7_SUB, F3_ADD_SUB, 26, 0, 19));
        cur_block = 6;
        emit(i_type(OP_IMM, F3_ADD_SUB, 28, 0, int'(LED_ADDR)));
        emit(i_type(OP_IMM, F3_ADD_SUB, 29, 0, $urandom_range(2047, 0)));
        emit(s_type(28, 29, 0));
        emit(i_type(OP_IMM, F3_XOR, 29, 29, 'h0FF));
        emit(s_type(28, 29, 0));                          // Final LED value
        cur_block = 7;
        for (int n = 0; n < 40; n++) begin
            k    = $urandom_range(5, 0);
            kind = $urandom_range(2, 0);
            imm  = $urandom_range(32'hFFFFF, 0);
            if (kind == 0)
                emit(r_type(k == 1 ? F7_SUB : F7_BASE, alu_f3[k], $urandom_range(31, 0),
                            $urandom_range(31, 0), $urandom_range(31, 0)));
            else if (kind == 1)
                emit(i_type(OP_IMM, alu_f3[k], $urandom_range(31, 0),
                            $urandom_range(31, 0), imm));
            else
                emit(u_type($urandom_range(31, 0), imm));
        end
        cur_block = 8;
        emit(j_type(0, 0));
    endtask

    initial begin
        cpuclk    = 1'b0;
        arst_n    = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        load_done = 1'b0;
        start     = 1'b0;
        void'($urandom(28850));
        build_program();
        start = 1'b1;
        repeat (16) @(negedge cpuclk);
        arst_n = 1'b1;
        for (int i = 0; i < prog_len; i++) begin
            @(negedge cpuclk);
            load_en   = 1'b1;
            load_addr = pc_t'(i * 4);
            load_data = image[i];
        end
        @(negedge cpuclk);
        load_en = 1'b0;
        @(negedge cpuclk);
        load_done = 1'b1;
        wait (done);
        $display("Retires expected %0d, errors %0d", n_expected, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // Eight cycles per retire covers stalls and flushes with margin
    initial begin : watchdog
        wait (load_done && ready);
        repeat (8 * n_expected + 200) @(posedge cpuclk);
        $display("Timeout: %0d of %0d expected retires never arrived", pending, n_expected);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* flist.f */
design/rv_isa_pkg.sv
design/pipe_pkg.sv
design/fetch_unit.sv
design/decode_unit.sv
design/execute_unit.sv
design/data_mem.sv
design/cpu_top.sv
tb/tb_checker.sv
tb/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_top \
    -f flist.f -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "Build or simulation did not complete"; cat build.log sim.log 2>/dev/null; }
grep -q "^STATUS: PASS$" sim.log 2>/dev/null && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed, see sim.log"; exit 1; }
